/* dv/l2_cache_ctrl_tb.sv */
// l2 cache controller testbench
// clock, reset, line memory model with random latency, requests from the cases file
`timescale 1ns/1ns
`default_nettype none

module l2_cache_ctrl_tb;
    import l2_pkg::*;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   ic_req, ic_ack, dc_req, dc_we, dc_ack;
    logic [addr_w-1:0]      ic_addr, dc_addr;
    logic [word_w-1:0]      dc_wd, rd_data;
    logic                   mem_req, mem_we, mem_done;
    logic [line_addr_w-1:0] mem_addr;
    logic [line_w-1:0]      mem_wd, mem_rd;

    // expectations handed to the checker
    logic [31:0]            ic_case, ic_exp, dc_case, dc_exp;
    logic                   ic_chk, dc_chk, wb_exp;
    logic [line_addr_w-1:0] wb_line;
    int                     errors, answered;

    logic        c_ic [64];
    logic        c_wr [64];
    logic [31:0] c_addr [64];
    logic [31:0] c_wdata [64];
    logic [31:0] c_exp [64];
    logic        c_chk [64];
    logic        c_pair [64];
    logic        c_wb [64];
    logic [25:0] c_wbl [64];
    int          n_cases = 0;
    logic        loaded = 1'b0;

    logic [line_w-1:0] mem_lines [logic [line_addr_w-1:0]];
    logic [31:0]       lcg_state = 32'h5b83d841;
    logic [31:0]       rnd;
    int                wait_n;
    int                idx;

    always #4 clk = ~clk;

    l2_cache_ctrl i_l2_cache_ctrl (
        .clk, .rst, .ic_req, .ic_addr, .ic_ack, .dc_req, .dc_we, .dc_addr, .dc_wd,
        .dc_ack, .rd_data, .mem_req, .mem_we, .mem_addr, .mem_wd, .mem_rd, .mem_done
    );

    l2_checker i_checker (
        .clk, .rst, .ic_req, .ic_ack, .dc_req, .dc_we, .dc_addr, .dc_wd, .dc_ack,
        .rd_data, .mem_req, .mem_we, .mem_addr, .mem_wd, .mem_done,
        .ic_case, .ic_exp, .ic_chk, .dc_case, .dc_exp, .dc_chk, .wb_exp, .wb_line,
        .errors, .answered
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // untouched lines hold each word's byte address in every lane
    function automatic logic [line_w-1:0] read_line(input logic [line_addr_w-1:0] la);
        logic [line_w-1:0] l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int k = 0; k < 4; k++) begin
            l[k*word_w +: word_w] = {4{la, 2'(k), 4'b0000}};
        end
        return l;
    endfunction

    // memory model with done after 1 to 4 cycles
    always begin
        @(posedge clk);
        if (!rst && mem_req) begin
            rnd    = lcg_next();
            wait_n = 1 + int'(rnd[31:30]);
            repeat (wait_n - 1) @(posedge clk);
            #1;
            mem_rd   = read_line(mem_addr);
            mem_done = 1'b1;
            @(posedge clk);
            if (mem_we) begin
                mem_lines[mem_addr] = mem_wd;
            end
            #1 mem_done = 1'b0;
        end
    end

    task automatic load_cases();
        int          fd;
        int          r;
        string       line;
        logic [7:0]  src_c, op_c;
        logic [31:0] a_v, w_v, e_v, l_v;
        int          h_v, p_v, b_v;
        fd = $fopen("dv/l2_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file dv/l2_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < 64) begin
                r = $fgets(line, fd);
                if (r == 0) break;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                r = $sscanf(line, "%s %s %h %h %h %d %d %d %h",
                            src_c, op_c, a_v, w_v, e_v, h_v, p_v, b_v, l_v);
                if (r != 9) continue;   // blank or malformed
                c_ic[n_cases]    = (src_c == "I");
                c_wr[n_cases]    = (op_c == "W");
                c_addr[n_cases]  = a_v;
                c_wdata[n_cases] = w_v;
                c_exp[n_cases]   = e_v;
                c_chk[n_cases]   = (h_v != 0);
                c_pair[n_cases]  = (p_v != 0);
                c_wb[n_cases]    = (b_v != 0);
                c_wbl[n_cases]   = l_v[25:0];
                n_cases++;
            end
            $fclose(fd);
        end
    endtask

    task automatic raise_port(input int c);
        if (c_ic[c]) begin
            ic_addr = c_addr[c];
            ic_exp  = c_exp[c];
            ic_chk  = c_chk[c];
            ic_case = c;
            ic_req  = 1'b1;
        end else begin
            dc_addr = c_addr[c];
            dc_we   = c_wr[c];
            dc_wd   = {4{c_wdata[c]}};
            dc_exp  = c_exp[c];
            dc_chk  = c_chk[c];
            dc_case = c;
            dc_req  = 1'b1;
        end
    endtask

    // case a alone or together with case b when b >= 0
    task automatic run_cases(input int a, input int b);
        logic got_i;
        logic got_d;
        #1;
        wb_exp  = c_wb[a];
        wb_line = c_wbl[a];
        raise_port(a);
        if (b >= 0) begin
            raise_port(b);
        end
        while (ic_req || dc_req) begin
            @(posedge clk);
            got_i = ic_ack;
            got_d = dc_ack;
            #1;
            if (got_i) ic_req = 1'b0;
            if (got_d) dc_req = 1'b0;
        end
        @(posedge clk);     // req stays low for a cycle
    endtask

    initial begin
        rst = 1'b1;
        ic_req = 1'b0;
        ic_addr = '0;
        dc_req = 1'b0;
        dc_we = 1'b0;
        dc_addr = '0;
        dc_wd = '0;
        mem_rd = '0;
        mem_done = 1'b0;
        ic_case = '0;
        ic_exp = '0;
        ic_chk = 1'b0;
        dc_case = '0;
        dc_exp = '0;
        dc_chk = 1'b0;
        wb_exp = 1'b0;
        wb_line = '0;
        load_cases();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        idx = 0;
        while (idx < n_cases) begin
            if (c_pair[idx] && idx + 1 < n_cases) begin
                run_cases(idx, idx + 1);
                idx += 2;
            end else begin
                run_cases(idx, -1);
                idx++;
            end
        end
        repeat (2) @(posedge clk);
        $display("%0d cases, %0d answered, %0d errors", n_cases, answered, errors);
        if (errors == 0 && answered == n_cases && n_cases > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (60 * n_cases + 16) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", 60 * n_cases);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/l2_cases.txt */
# src op addr wdata exp_lane hit pair wb wb_line  (hit=1: hit timing checked, no mem traffic)
# pair=1: raised in the same cycle as the next line; wb=1: write-back to wb_line expected
I R 00000050 00000000 00000050 0 0 0 0000000
I R 00000050 00000000 00000050 1 0 0 0000000
D W 00000060 a5a5a5a5 00000000 1 0 0 0000000
D R 00000060 00000000 a5a5a5a5 1 0 0 0000000
D R 00000070 00000000 00000070 1 0 0 0000000
D W 00008150 11112222 00000000 0 0 0 0000000
D R 00010140 00000000 00010140 0 0 0 0000000
I R 00018160 00000000 00018160 0 0 0 0000000
D R 00020170 00000000 00020170 0 0 0 0000000
D R 00028140 00000000 00028140 0 0 1 0000205
D R 00008150 00000000 11112222 0 0 0 0000000
D W 00010150 deadbeef 00000000 1 0 0 0000000
I R 00020170 00000000 00020170 1 0 0 0000000
D R 00030140 00000000 00030140 0 0 0 0000000
D R 00038140 00000000 00038140 0 0 0 0000000
D R 00040140 00000000 00040140 0 0 1 0000405
D R 00020170 00000000 00020170 1 0 0 0000000
I R 00000050 00000000 00000050 1 1 0 0000000
D R 00000060 00000000 a5a5a5a5 0 0 0 0000000
I R 00000070 00000000 00000070 1 1 0 0000000
D W 00000070 77777777 00000000 0 0 0 0000000
D R 00000070 00000000 77777777 1 0 0 0000000

/* dv/l2_checker.sv */
// l2 cache checker
// watches acknowledges and memory writes, keeps its own copy of every data write
// and compares read words and write-back lines with it
`timescale 1ns/1ns
`default_nettype none

module l2_checker (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               ic_req,
    input  wire                               ic_ack,
    input  wire                               dc_req,
    input  wire                               dc_we,
    input  wire [l2_pkg::addr_w-1:0]          dc_addr,
    input  wire [l2_pkg::word_w-1:0]          dc_wd,
    input  wire                               dc_ack,
    input  wire [l2_pkg::word_w-1:0]          rd_data,
    input  wire                               mem_req,
    input  wire                               mem_we,
    input  wire [l2_pkg::line_addr_w-1:0]     mem_addr,
    input  wire [l2_pkg::line_w-1:0]          mem_wd,
    input  wire                               mem_done,
    input  wire [31:0]                        ic_case,
    input  wire [31:0]                        ic_exp,
    input  wire                               ic_chk,
    input  wire [31:0]                        dc_case,
    input  wire [31:0]                        dc_exp,
    input  wire                               dc_chk,
    input  wire                               wb_exp,
    input  wire [l2_pkg::line_addr_w-1:0]     wb_line,
    output int                                errors,
    output int                                answered
);
    import l2_pkg::*;

    logic [word_w-1:0] shadow [logic [27:0]];  // written words by word address
    int   ic_cyc;
    int   dc_cyc;
    logic ic_mem;
    logic dc_mem;
    logic wb_seen;
    int   last_err;

    // memory contents a line should have: written words, else the address pattern
    function automatic logic [line_w-1:0] expected_line(input logic [line_addr_w-1:0] la);
        logic [line_w-1:0] l;
        logic [27:0]       wa;
        for (int k = 0; k < 4; k++) begin
            wa = {la, 2'(k)};
            if (shadow.exists(wa)) begin
                l[k*word_w +: word_w] = shadow[wa];
            end else begin
                l[k*word_w +: word_w] = {4{wa, 4'b0000}};
            end
        end
        return l;
    endfunction

    task automatic finish_case(input int id, input logic is_read, input logic [31:0] exp,
                               input logic chk, input int cyc, input logic mem);
        if (is_read && rd_data !== {4{exp}}) begin
            errors++;
            $display("** Error at %0t ns: rd_data = %h, expected %h", $time, rd_data, {4{exp}});
        end
        if (chk && (cyc != 4 || mem)) begin
            errors++;
            $display("case %0d: hit not answered 3 cycles after capture without memory traffic", id);
        end
        if (wb_exp && !wb_seen) begin
            errors++;
            $display("case %0d: expected write-back to line %h never happened", id, wb_line);
        end
        $display("case %0d %s", id, (errors == last_err) ? "ok" : "mismatch");
        last_err = errors;
        answered++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ic_cyc   = 0;
            dc_cyc   = 0;
            ic_mem   = 1'b0;
            dc_mem   = 1'b0;
            wb_seen  = 1'b0;
            errors   = 0;
            answered = 0;
            last_err = 0;
        end else begin
            if (mem_req && mem_we && mem_done) begin
                wb_seen = 1'b1;
                if (!wb_exp) begin
                    errors++;
                    $display("unexpected write-back to line %h at %0t ns", mem_addr, $time);
                end else begin
                    if (mem_addr !== wb_line) begin
                        errors++;
                        $display("** Error at %0t ns: mem_addr = %h, expected %h",
                                 $time, mem_addr, wb_line);
                    end
                    if (mem_wd !== expected_line(wb_line)) begin
                        errors++;
                        $display("** Error at %0t ns: mem_wd = %h, expected %h",
                                 $time, mem_wd, expected_line(wb_line));
                    end
                end
            end
            if (ic_ack && dc_ack) begin
                errors++;
                $display("both ports acknowledged in the same cycle at %0t ns", $time);
            end
            if ((ic_ack && !ic_req) || (dc_ack && !dc_req)) begin
                errors++;
                $display("acknowledge on a port with no request at %0t ns", $time);
            end
            if (dc_ack && ic_req && !ic_ack) begin
                errors++;
                $display("data port answered ahead of a waiting instruction request");
            end
            if (ic_ack) begin
                finish_case(int'(ic_case), 1'b1, ic_exp, ic_chk, ic_cyc, ic_mem);
                wb_seen = 1'b0;
                ic_cyc  = 0;
                ic_mem  = 1'b0;
            end else if (ic_req) begin
                ic_cyc++;
                ic_mem = ic_mem || mem_req;
            end
            if (dc_ack) begin
                finish_case(int'(dc_case), !dc_we, dc_exp, dc_chk, dc_cyc, dc_mem);
                if (dc_we) begin
                    shadow[dc_addr[31:4]] = dc_wd;
                end
                wb_seen = 1'b0;
                dc_cyc  = 0;
                dc_mem  = 1'b0;
            end else if (dc_req) begin
                dc_cyc++;
                dc_mem = dc_mem || mem_req;
            end
        end
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/l2_pkg.sv
rtl/l2_req_arbiter.sv
rtl/l2_tag_store.sv
rtl/l2_way_select.sv
rtl/l2_data_store.sv
rtl/l2_ctrl_fsm.sv
rtl/l2_cache_ctrl.sv
dv/l2_checker.sv
dv/l2_cache_ctrl_tb.sv

/* rtl/l2_cache_ctrl.sv */
// l2 cache controller top
// four-way write-back cache shared by an instruction and a data port
`timescale 1ns/1ns
`default_nettype none

module l2_cache_ctrl (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               ic_req,
    input  wire [l2_pkg::addr_w-1:0]          ic_addr,
    output logic                              ic_ack,
    input  wire                               dc_req,
    input  wire                               dc_we,
    input  wire [l2_pkg::addr_w-1:0]          dc_addr,
    input  wire [l2_pkg::word_w-1:0]          dc_wd,
    output logic                              dc_ack,
    output logic [l2_pkg::word_w-1:0]         rd_data,
    output logic                              mem_req,
    output logic                              mem_we,
    output logic [l2_pkg::line_addr_w-1:0]    mem_addr,
    output logic [l2_pkg::line_w-1:0]         mem_wd,
    input  wire [l2_pkg::line_w-1:0]          mem_rd,
    input  wire                               mem_done
);
    import l2_pkg::*;

    logic                   req_valid, req_we, accept, resp_valid;
    l2_addr_u               req_addr;
    logic [word_w-1:0]      req_wd;
    logic                   tag_rd_en, tag_wr_en, tag_wr_dirty, plru_en, data_rd_en;
    logic [way_w-1:0]       tag_wr_way, plru_way, data_way;
    logic [num_ways-1:0][tag_w-1:0] tags;
    logic [num_ways-1:0]    valids, dirtys;
    logic [plru_w-1:0]      plru;
    logic                   hit, victim_dirty;
    logic [way_w-1:0]       hit_way, victim_way;
    logic [tag_w-1:0]       victim_tag;
    logic [num_ways-1:0][line_w/word_w-1:0] word_we;
    logic [line_w-1:0]      wr_line, rd_line;

    l2_req_arbiter i_arbiter (
        .clk, .rst, .ic_req, .ic_addr, .dc_req, .dc_we, .dc_addr, .dc_wd,
        .accept, .resp_valid, .req_valid, .req_addr, .req_we, .req_wd,
        .ic_ack, .dc_ack
    );

    l2_tag_store i_tag_store (
        .clk, .rst, .rd_en(tag_rd_en), .index(req_addr.lookup.index),
        .wr_en(tag_wr_en), .wr_way(tag_wr_way), .wr_tag(req_addr.lookup.tag),
        .wr_dirty(tag_wr_dirty), .plru_en, .plru_way,
        .tags, .valids, .dirtys, .plru
    );

    l2_way_select i_way_select (
        .addr(req_addr), .tags, .valids, .dirtys, .plru,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    l2_data_store i_data_store (
        .clk, .rd_en(data_rd_en), .index(req_addr.lookup.index),
        .way(data_way), .word_we, .wr_line, .rd_line
    );

    l2_ctrl_fsm i_ctrl_fsm (
        .clk, .rst, .req_valid, .req_addr, .req_we, .req_wd,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .rd_line, .mem_rd, .mem_done, .accept, .resp_valid, .rd_data,
        .tag_rd_en, .tag_wr_en, .tag_wr_way, .tag_wr_dirty, .plru_en, .plru_way,
        .data_rd_en, .data_way, .word_we, .wr_line,
        .mem_req, .mem_we, .mem_addr, .mem_wd
    );

endmodule

`default_nettype wire

/* rtl/l2_ctrl_fsm.sv */
// l2 controller FSM
// lookup, hit, write-back and fill sequencing with the memory port,
// word extraction on reads and word merge on writes
`timescale 1ns/1ns
`default_nettype none

module l2_ctrl_fsm (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   req_valid,
    input  wire l2_pkg::l2_addr_u                 req_addr,
    input  wire                                   req_we,
    input  wire [l2_pkg::word_w-1:0]              req_wd,
    input  wire                                   hit,
    input  wire [l2_pkg::way_w-1:0]               hit_way,
    input  wire [l2_pkg::way_w-1:0]               victim_way,
    input  wire                                   victim_dirty,
    input  wire [l2_pkg::tag_w-1:0]               victim_tag,
    input  wire [l2_pkg::line_w-1:0]              rd_line,
    input  wire [l2_pkg::line_w-1:0]              mem_rd,
    input  wire                                   mem_done,
    output logic                                  accept,
    output logic                                  resp_valid,
    output logic [l2_pkg::word_w-1:0]             rd_data,
    output logic                                  tag_rd_en,
    output logic                                  tag_wr_en,
    output logic [l2_pkg::way_w-1:0]              tag_wr_way,
    output logic                                  tag_wr_dirty,
    output logic                                  plru_en,
    output logic [l2_pkg::way_w-1:0]              plru_way,
    output logic                                  data_rd_en,
    output logic [l2_pkg::way_w-1:0]              data_way,
    output logic [l2_pkg::num_ways-1:0][l2_pkg::line_w/l2_pkg::word_w-1:0] word_we,
    output logic [l2_pkg::line_w-1:0]             wr_line,
    output logic                                  mem_req,
    output logic                                  mem_we,
    output logic [l2_pkg::line_addr_w-1:0]        mem_addr,
    output logic [l2_pkg::line_w-1:0]             mem_wd
);
    import l2_pkg::*;

    l2_state_e         state;
    l2_state_e         next_state;
    logic [way_w-1:0]  way_q;       // victim way for the whole miss
    logic [tag_w-1:0]  vtag_q;
    logic [word_w-1:0] word_q;
    logic              fill_done;

    assign fill_done = (state == st_fill) && mem_done;

    always_comb begin
        next_state = state;
        case (state)
            st_idle:       if (req_valid) next_state = st_lookup;
            st_lookup:     next_state = st_compare;
            st_compare: begin
                if (hit) begin
                    next_state = st_respond;
                end else begin
                    next_state = victim_dirty ? st_write_back : st_fill;
                end
            end
            st_write_back: if (mem_done) next_state = st_fill;
            st_fill:       if (mem_done) next_state = st_respond;
            default:       next_state = st_idle;    // respond lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_compare) begin
            way_q  <= victim_way;
            vtag_q <= victim_tag;
        end
        if ((state == st_compare && hit) || fill_done) begin
            word_q <= wr_line[req_addr.lookup.word*word_w +: word_w];
        end
    end

    // fill line from memory, or the hit line, with the new word on top
    always_comb begin
        wr_line = (state == st_fill) ? mem_rd : rd_line;
        if (req_we) begin
            wr_line[req_addr.lookup.word*word_w +: word_w] = req_wd;
        end
    end

    always_comb begin
        word_we      = '0;
        tag_wr_en    = 1'b0;
        tag_wr_way   = way_q;
        tag_wr_dirty = req_we;
        plru_en      = 1'b0;
        plru_way     = way_q;
        if (state == st_compare && hit) begin
            plru_en    = 1'b1;
            plru_way   = hit_way;
            tag_wr_way = hit_way;
            if (req_we) begin
                word_we[hit_way][req_addr.lookup.word] = 1'b1;
                tag_wr_en = 1'b1;
            end
        end else if (fill_done) begin
            word_we[way_q] = '1;
            tag_wr_en      = 1'b1;
            plru_en        = 1'b1;
        end
    end

    assign accept     = (state == st_idle) && req_valid;
    assign resp_valid = (state == st_respond);
    assign rd_data    = word_q;
    assign tag_rd_en  = (state == st_lookup);
    assign data_rd_en = (state == st_lookup);
    assign data_way   = (state == st_compare) ? (hit ? hit_way : victim_way) : way_q;

    assign mem_req  = (state == st_write_back) || (state == st_fill);
    assign mem_we   = (state == st_write_back);
    assign mem_addr = (state == st_write_back) ? {vtag_q, req_addr.lookup.index}
                                               : req_addr.line.line_addr;
    assign mem_wd   = rd_line;  // victim line, held since lookup

endmodule

`default_nettype wire

/* rtl/l2_data_store.sv */
// l2 data store
// four ways of 512-bit lines, word-granular writes, registered read of all ways
`timescale 1ns/1ns
`default_nettype none

module l2_data_store (
    input  wire                                                       clk,
    input  wire                                                       rd_en,
    input  wire [l2_pkg::index_w-1:0]                                 index,
    input  wire [l2_pkg::way_w-1:0]                                   way,
    input  wire [l2_pkg::num_ways-1:0][l2_pkg::line_w/l2_pkg::word_w-1:0] word_we,
    input  wire [l2_pkg::line_w-1:0]                                  wr_line,
    output logic [l2_pkg::line_w-1:0]                                 rd_line
);
    import l2_pkg::*;

    logic [line_w-1:0] line_mem [num_ways][1 << index_w];
    logic [line_w-1:0] rd_q     [num_ways];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            for (int k = 0; k < line_w / word_w; k++) begin
                if (word_we[w][k]) begin
                    line_mem[w][index][k*word_w +: word_w] <= wr_line[k*word_w +: word_w];
                end
            end
            if (rd_en) begin
                rd_q[w] <= line_mem[w][index];
            end
        end
    end

    assign rd_line = rd_q[way];     // hit way, or victim during write-back

endmodule

`default_nettype wire

/* rtl/l2_pkg.sv */
// l2 cache shared definitions
// geometry, controller state encoding and the two address views
`default_nettype none

package l2_pkg;

    localparam int addr_w      = 32;
    localparam int tag_w       = 17;
    localparam int index_w     = 9;
    localparam int word_sel_w  = 2;
    localparam int byte_w      = 4;
    localparam int num_ways    = 4;
    localparam int way_w       = 2;
    localparam int word_w      = 128;
    localparam int line_w      = 512;
    localparam int line_addr_w = 26;
    localparam int plru_w      = 3;

    // one byte address, seen either as lookup fields or as a line address
    typedef union packed {
        struct packed {
            logic [tag_w-1:0]      tag;
            logic [index_w-1:0]    index;
            logic [word_sel_w-1:0] word;
            logic [byte_w-1:0]     byte_off;
        } lookup;
        struct packed {
            logic [line_addr_w-1:0] line_addr;
            logic [5:0]             low;    // word and byte bits
        } line;
    } l2_addr_u;

    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_lookup     = 3'd1,
        st_compare    = 3'd2,
        st_write_back = 3'd3,
        st_fill       = 3'd4,
        st_respond    = 3'd5
    } l2_state_e;

endpackage

`default_nettype wire

/* rtl/l2_req_arbiter.sv */
// l2 request arbiter
// holds one request from the instruction or data port, instruction port first,
// and steers the acknowledge back to whoever asked
`timescale 1ns/1ns
`default_nettype none

module l2_req_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          ic_req,
    input  wire [l2_pkg::addr_w-1:0]     ic_addr,
    input  wire                          dc_req,
    input  wire                          dc_we,
    input  wire [l2_pkg::addr_w-1:0]     dc_addr,
    input  wire [l2_pkg::word_w-1:0]     dc_wd,
    input  wire                          accept,
    input  wire                          resp_valid,
    output logic                         req_valid,
    output l2_pkg::l2_addr_u             req_addr,
    output logic                         req_we,
    output logic [l2_pkg::word_w-1:0]    req_wd,
    output logic                         ic_ack,
    output logic                         dc_ack
);

    logic full;     // a request is held
    logic taken;    // fsm has started on it
    logic src_ic;

    always_ff @(posedge clk) begin
        if (rst) begin
            full  <= 1'b0;
            taken <= 1'b0;
        end else if (resp_valid) begin
            full  <= 1'b0;
            taken <= 1'b0;
        end else begin
            if (!full && (ic_req || dc_req)) begin
                full <= 1'b1;
            end
            if (accept) begin
                taken <= 1'b1;
            end
        end
    end

    // payload follows the ports until captured
    always_ff @(posedge clk) begin
        if (!full) begin
            src_ic   <= ic_req;
            req_addr <= ic_req ? ic_addr : dc_addr;
            req_we   <= !ic_req && dc_we;   // instruction port never writes
            req_wd   <= dc_wd;
        end
    end

    assign req_valid = full && !taken;
    assign ic_ack    = resp_valid && src_ic;
    assign dc_ack    = resp_valid && !src_ic;

endmodule

`default_nettype wire

/* rtl/l2_tag_store.sv */
// l2 tag store
// tag, valid, dirty and tree plru bits per set, all ways read at once
`timescale 1ns/1ns
`default_nettype none

module l2_tag_store (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        rd_en,
    input  wire [l2_pkg::index_w-1:0]                  index,
    input  wire                                        wr_en,
    input  wire [l2_pkg::way_w-1:0]                    wr_way,
    input  wire [l2_pkg::tag_w-1:0]                    wr_tag,
    input  wire                                        wr_dirty,
    input  wire                                        plru_en,
    input  wire [l2_pkg::way_w-1:0]                    plru_way,
    output logic [l2_pkg::num_ways-1:0][l2_pkg::tag_w-1:0] tags,
    output logic [l2_pkg::num_ways-1:0]                valids,
    output logic [l2_pkg::num_ways-1:0]                dirtys,
    output logic [l2_pkg::plru_w-1:0]                  plru
);
    import l2_pkg::*;

    logic [tag_w-1:0]    tag_mem [num_ways][1 << index_w];
    logic [num_ways-1:0] valid_q [1 << index_w];
    logic [num_ways-1:0] dirty_q [1 << index_w];
    logic [plru_w-1:0]   plru_q  [1 << index_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < (1 << index_w); s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (wr_en) begin
                valid_q[index][wr_way] <= 1'b1;
                dirty_q[index][wr_way] <= wr_dirty;
            end
            if (plru_en) begin
                plru_q[index][0] <= ~plru_way[1];   // point at the other half
                if (plru_way[1]) begin
                    plru_q[index][2] <= ~plru_way[0];
                end else begin
                    plru_q[index][1] <= ~plru_way[0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][index] <= wr_tag;
        end
        if (rd_en) begin
            for (int w = 0; w < num_ways; w++) begin
                tags[w] <= tag_mem[w][index];
            end
            valids <= valid_q[index];
            dirtys <= dirty_q[index];
            plru   <= plru_q[index];
        end
    end

endmodule

`default_nettype wire

/* rtl/l2_way_select.sv */
// l2 way select
// tag compare across four ways and victim choice, invalid way first then plru tree
`timescale 1ns/1ns
`default_nettype none

module l2_way_select (
    input  wire l2_pkg::l2_addr_u                          addr,
    input  wire [l2_pkg::num_ways-1:0][l2_pkg::tag_w-1:0]  tags,
    input  wire [l2_pkg::num_ways-1:0]                     valids,
    input  wire [l2_pkg::num_ways-1:0]                     dirtys,
    input  wire [l2_pkg::plru_w-1:0]                       plru,
    output logic                                           hit,
    output logic [l2_pkg::way_w-1:0]                       hit_way,
    output logic [l2_pkg::way_w-1:0]                       victim_way,
    output logic                                           victim_dirty,
    output logic [l2_pkg::tag_w-1:0]                       victim_tag
);
    import l2_pkg::*;

    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = '0;
        // walk downwards so the lowest way wins
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (valids[w] && tags[w] == addr.lookup.tag) begin
                hit     = 1'b1;
                hit_way = way_w'(w);
            end
            if (!valids[w]) begin
                victim_way = way_w'(w);
            end
        end
        if (&valids) begin
            victim_way = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};
        end
    end

    assign victim_dirty = dirtys[victim_way];
    assign victim_tag   = tags[victim_way];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the l2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module l2_cache_ctrl_tb -o l2_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/l2_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "no pass message in sim.log"
    exit 1
fi
exit 0
